//--- sim.f
logic/cpu_pkg.sv
logic/decoder.sv
logic/registers.sv
logic/alu.sv
logic/bus_wb8.sv
logic/control.sv
logic/cpu.sv
tests/wb_memory.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f sim.f -o cpu_sim \
    && ./obj_dir/cpu_sim \
    || exit 1

//--- tests/cpu_tb.sv
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, reset, ack, cyc, stb, we;
    logic [7:0] rdata, wdata;
    cpu_pkg::word_t adr;

    cpu_pkg::word_t pc, ptr, exp_adr[$];
    cpu_pkg::word_t park_pc, last_read;
    logic [7:0] exp_byte[$];
    logic [31:0] lfsr_q;
    int n_instr, writes_seen, reads_seen, reset_cycles;
    logic built;

    localparam logic [6:0] OPC_LUI = 7'b0110111, OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR = 7'b1100111, OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    cpu #(.reset_vector(32'd0)) uut (
        .clk(clk), .reset(reset), .ack(ack), .rdata(rdata),
        .adr(adr), .wdata(wdata), .cyc(cyc), .stb(stb), .we(we)
    );

    wb_memory u_mem (
        .clk(clk), .adr(adr), .wdata(wdata), .cyc(cyc), .stb(stb), .we(we),
        .ack(ack), .rdata(rdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b) lfsr_q = lfsr_q ^ 32'h80200003;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // rv32i semantics
    function automatic cpu_pkg::word_t ref_alu(cpu_pkg::alu_op_t op, cpu_pkg::word_t a,
                                               cpu_pkg::word_t b);
        case (op)
            cpu_pkg::ALU_ADD:  return a + b;
            cpu_pkg::ALU_SUB:  return a - b;
            cpu_pkg::ALU_SLL:  return a << b[4:0];
            cpu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            cpu_pkg::ALU_XOR:  return a ^ b;
            cpu_pkg::ALU_SRL:  return a >> b[4:0];
            cpu_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            cpu_pkg::ALU_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(logic [2:0] f3, cpu_pkg::word_t a, cpu_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // {alt, funct3} for each operation
    function automatic logic [3:0] op_code(cpu_pkg::alu_op_t op);
        case (op)
            cpu_pkg::ALU_ADD:  return 4'b0000;
            cpu_pkg::ALU_SUB:  return 4'b1000;
            cpu_pkg::ALU_SLL:  return 4'b0001;
            cpu_pkg::ALU_SLT:  return 4'b0010;
            cpu_pkg::ALU_SLTU: return 4'b0011;
            cpu_pkg::ALU_XOR:  return 4'b0100;
            cpu_pkg::ALU_SRL:  return 4'b0101;
            cpu_pkg::ALU_SRA:  return 4'b1101;
            cpu_pkg::ALU_OR:   return 4'b0110;
            default:           return 4'b0111;
        endcase
    endfunction

    function automatic cpu_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic cpu_pkg::word_t enc_b(logic [12:0] off, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic cpu_pkg::word_t enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(cpu_pkg::word_t w);
        for (int i = 0; i < 4; i++) begin
            u_mem.mem[pc[11:0] + i] = w[8*i +: 8];
        end
        pc = pc + 32'd4;
        n_instr++;
    endtask

    task automatic load_const(logic [4:0] rd, cpu_pkg::word_t v);
        cpu_pkg::word_t upper;
        upper = (v + 32'h800) >> 12;
        emit({upper[19:0], rd, OPC_LUI});
        emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OPIMM));
    endtask

    // sw rs2 to the store pointer, then step it
    task automatic store_expect(logic [4:0] rs2, cpu_pkg::word_t v);
        emit(enc_s(12'd0, rs2, 5'd31, 3'b010));
        emit(enc_i(12'd4, 5'd31, 3'b000, 5'd31, OPC_OPIMM));
        for (int i = 0; i < 4; i++) begin
            exp_adr.push_back(ptr + i);
            exp_byte.push_back(v[8*i +: 8]);
        end
        ptr = ptr + 32'd4;
    endtask

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_addr(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic build_program();
        cpu_pkg::alu_op_t ops[10] = '{cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_SLL,
            cpu_pkg::ALU_SLT, cpu_pkg::ALU_SLTU, cpu_pkg::ALU_XOR, cpu_pkg::ALU_SRL,
            cpu_pkg::ALU_SRA, cpu_pkg::ALU_OR, cpu_pkg::ALU_AND};
        cpu_pkg::word_t a, b, pa[3], pb[3], q;
        cpu_pkg::alu_op_t op;
        logic [3:0] code;
        logic [11:0] imm;
        logic [2:0] f3s[6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pa = '{32'd5, 32'hFFFFFFF0, 32'd5};
        pb = '{32'd5, 32'd5, 32'hFFFFFFF0};
        load_const(5'd31, ptr);
        for (int k = 0; k < 40; k++) begin
            op = ops[rand_bits(8) % 10];
            a = rand_bits(32);
            b = rand_bits(32);
            code = op_code(op);
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit({1'b0, code[3], 5'b0, 5'd2, 5'd1, code[2:0], 5'd3, 7'b0110011});
            store_expect(5'd3, ref_alu(op, a, b));
        end
        for (int k = 0; k < 20; k++) begin
            do op = ops[rand_bits(8) % 10]; while (op == cpu_pkg::ALU_SUB);
            a = rand_bits(32);
            code = op_code(op);
            imm = rand_bits(12);
            if (code[2:0] == 3'b001 || code[2:0] == 3'b101) imm = {1'b0, code[3], 5'b0, imm[4:0]};
            load_const(5'd1, a);
            emit(enc_i(imm, 5'd1, code[2:0], 5'd3, OPC_OPIMM));
            store_expect(5'd3, ref_alu(op, a, {{20{imm[11]}}, imm}));
        end
        for (int k = 0; k < 2; k++) begin
            a = rand_bits(20);
            emit({a[19:0], 5'd3, OPC_LUI});
            store_expect(5'd3, {a[19:0], 12'b0});
            q = pc;
            emit({a[19:0], 5'd3, OPC_AUIPC});
            store_expect(5'd3, q + {a[19:0], 12'b0});
        end
        u_mem.mem[12'hB00] = 8'h96;
        u_mem.mem[12'hB01] = 8'hF3;
        u_mem.mem[12'hB02] = 8'h5A;
        u_mem.mem[12'hB03] = 8'h8C;
        load_const(5'd30, 32'hB00);
        emit(enc_i(12'd0, 5'd30, 3'b010, 5'd5, OPC_LOAD));
        store_expect(5'd5, 32'h8C5AF396);
        emit(enc_i(12'd3, 5'd30, 3'b000, 5'd6, OPC_LOAD));
        store_expect(5'd6, 32'hFFFFFF8C);
        emit(enc_i(12'd3, 5'd30, 3'b100, 5'd7, OPC_LOAD));
        store_expect(5'd7, 32'h0000008C);
        load_const(5'd8, 32'h12345678);
        emit(enc_s(12'd0, 5'd8, 5'd31, 3'b000));
        emit(enc_i(12'd4, 5'd31, 3'b000, 5'd31, OPC_OPIMM));
        exp_adr.push_back(ptr);
        exp_byte.push_back(8'h78);
        ptr = ptr + 32'd4;
        foreach (f3s[i]) begin
            for (int j = 0; j < 3; j++) begin
                load_const(5'd1, pa[j]);
                load_const(5'd2, pb[j]);
                emit(enc_i(12'h2A, 5'd0, 3'b000, 5'd3, OPC_OPIMM));
                emit(enc_b(13'd8, 5'd2, 5'd1, f3s[i]));
                emit(enc_i(12'h15, 5'd0, 3'b000, 5'd3, OPC_OPIMM));  // not-taken path only
                store_expect(5'd3, ref_branch(f3s[i], pa[j], pb[j]) ? 32'h2A : 32'h15);
            end
        end
        q = pc;
        emit(enc_j(21'd12, 5'd4));
        emit(enc_s(12'd0, 5'd0, 5'd31, 3'b010));
        emit(enc_s(12'd0, 5'd0, 5'd31, 3'b010));
        store_expect(5'd4, q + 32'd4);
        q = pc;
        load_const(5'd10, q + 32'd16);
        emit(enc_i(12'd4, 5'd10, 3'b000, 5'd11, OPC_JALR));
        emit(enc_s(12'd0, 5'd0, 5'd31, 3'b010));
        emit(enc_s(12'd0, 5'd0, 5'd31, 3'b010));
        store_expect(5'd11, q + 32'd12);
        load_const(5'd12, 32'h5A5A);
        emit(32'h0000000F);   // fence
        emit(32'h00000673);   // system, dropped
        emit(32'h0000067B);   // unknown opcode
        store_expect(5'd12, 32'h5A5A);
        park_pc = pc;
        emit(enc_j(21'd0, 5'd0));  // park
        if (pc > 32'hB00) begin
            $display("program overlaps the data area");
            fail_now();
        end
    endtask

    // bus monitor, compares each accepted byte
    always @(posedge clk) begin
        if (reset) begin
            if (reset_cycles > 0 && cyc !== 1'b0) begin
                $display("cyc went high while reset was asserted");
                fail_now();
            end
            reset_cycles++;
        end else if (cyc && stb && ack) begin
            if (!we) begin
                if (reads_seen < 4) check_addr("fetch adr", reads_seen, adr);
                reads_seen++;
                last_read = adr;
            end else if (exp_adr.size() == 0) begin
                $display("store byte written after the last expected one");
                fail_now();
            end else begin
                check_addr("store adr", exp_adr.pop_front(), adr);
                check_byte("store wdata", exp_byte.pop_front(), wdata);
                writes_seen++;
            end
        end
    end

    initial begin
        wait (built);
        repeat (n_instr * 60) @(posedge clk);
        $display("timeout, the program did not finish its stores");
        fail_now();
    end

    initial begin
        int n_expected;
        clk = 1'b0;
        reset = 1'b1;
        built = 1'b0;
        lfsr_q = 32'haa9a;
        pc = 32'd0;
        ptr = 32'hC00;
        n_instr = 0;
        writes_seen = 0;
        reads_seen = 0;
        reset_cycles = 0;
        @(posedge clk);
        build_program();
        n_expected = exp_adr.size();
        built = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (writes_seen == n_expected);
        repeat (300) @(posedge clk);  // catch stray stores
        // by now the core spins on the park jump
        check_addr("park fetch adr", park_pc, {last_read[31:2], 2'b00});
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/wb_memory.sv
`default_nettype none

module wb_memory (
    input  wire        clk,
    input  wire [31:0] adr,
    input  wire [7:0]  wdata,
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    output logic       ack,
    output logic [7:0] rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [4096];
    logic [31:0] lfsr_q;
    logic pending;
    logic [1:0] wait_left;

    // galois lfsr, one step per bit taken
    function automatic logic [1:0] draw_delay();
        logic [1:0] v;
        logic b;
        v = '0;
        for (int i = 0; i < 2; i++) begin
            b = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b) lfsr_q = lfsr_q ^ 32'h80200003;
            v = {v[0], b};
        end
        return v;
    endfunction

    initial begin
        ack = 1'b0;
        rdata = 8'h00;
        pending = 1'b0;
        wait_left = 2'd0;
        lfsr_q = 32'haa9a;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = i[7:0] ^ i[11:4];  // fill depends on all 12 address bits
        end
    end

    always @(posedge clk) begin
        ack <= 1'b0;
        if (cyc && stb && !ack) begin
            if (!pending) begin
                pending <= 1'b1;
                wait_left <= draw_delay();
            end else if (wait_left == 2'd0) begin
                ack <= 1'b1;
                pending <= 1'b0;
                rdata <= mem[adr[11:0]];
                if (we) mem[adr[11:0]] <= wdata;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none

module cpu #(
    parameter cpu_pkg::word_t reset_vector = 32'd0
) (
    input  wire             clk,
    input  wire             reset,
    input  wire             ack,
    input  wire [7:0]       rdata,
    output cpu_pkg::word_t  adr,
    output logic [7:0]      wdata,
    output logic            cyc,
    output logic            stb,
    output logic            we
);

    cpu_pkg::word_t pc, instr, imm, val1, val2;
    cpu_pkg::word_t alu_s1, alu_s2, alu_result, bus_addr, bus_result, reg_wdata;
    cpu_pkg::opcode_t opcode;
    cpu_pkg::reg_addr_t rs1, rs2, rd;
    logic [2:0] funct3;
    logic alt, lt, ltu, eq, busy;
    logic alu_en, bus_en, reg_we, pc_we, instr_we;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::bus_op_t bus_op;
    cpu_pkg::s1_sel_t s1_sel;
    cpu_pkg::s2_sel_t s2_sel;
    cpu_pkg::addr_sel_t addr_sel;
    cpu_pkg::wb_sel_t wb_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_we) begin
            pc <= {alu_result[31:1], 1'b0};  // jalr clears bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (instr_we) begin
            instr <= bus_result;
        end
    end

    always_comb begin
        alu_s1 = (s1_sel == cpu_pkg::S1_PC) ? pc : val1;
        case (s2_sel)
            cpu_pkg::S2_IMM:     alu_s2 = imm;
            cpu_pkg::S2_INSTLEN: alu_s2 = cpu_pkg::instr_len;
            default:             alu_s2 = val2;
        endcase
        bus_addr = (addr_sel == cpu_pkg::ADDR_PC) ? pc : alu_result;
        case (wb_sel)
            cpu_pkg::WB_BUS: reg_wdata = bus_result;
            cpu_pkg::WB_IMM: reg_wdata = imm;
            default:         reg_wdata = alu_result;
        endcase
    end

    decoder u_decoder (
        .instr(instr), .opcode(opcode), .rs1(rs1), .rs2(rs2), .rd(rd),
        .funct3(funct3), .alt(alt), .imm(imm)
    );

    registers u_registers (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we),
        .wdata(reg_wdata), .val1(val1), .val2(val2)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .en(alu_en), .op(alu_op), .s1(alu_s1), .s2(alu_s2),
        .result(alu_result), .lt(lt), .ltu(ltu), .eq(eq)
    );

    // store data always comes from rs2
    bus_wb8 u_bus (
        .clk(clk), .reset(reset), .en(bus_en), .op(bus_op), .addr(bus_addr),
        .data(val2), .ack(ack), .rdata(rdata), .busy(busy), .result(bus_result),
        .adr(adr), .wdata(wdata), .cyc(cyc), .stb(stb), .we(we)
    );

    control u_control (
        .clk(clk), .reset(reset), .opcode(opcode), .funct3(funct3), .alt(alt),
        .lt(lt), .ltu(ltu), .eq(eq), .busy(busy),
        .alu_en(alu_en), .alu_op(alu_op), .s1_sel(s1_sel), .s2_sel(s2_sel),
        .bus_en(bus_en), .bus_op(bus_op), .addr_sel(addr_sel), .wb_sel(wb_sel),
        .reg_we(reg_we), .pc_we(pc_we), .instr_we(instr_we)
    );

endmodule

`default_nettype wire

//--- logic/control.sv
`default_nettype none

module control (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_pkg::opcode_t   opcode,
    input  wire [2:0]               funct3,
    input  wire                     alt,
    input  wire                     lt,
    input  wire                     ltu,
    input  wire                     eq,
    input  wire                     busy,
    output logic                    alu_en,
    output cpu_pkg::alu_op_t        alu_op,
    output cpu_pkg::s1_sel_t        s1_sel,
    output cpu_pkg::s2_sel_t        s2_sel,
    output logic                    bus_en,
    output cpu_pkg::bus_op_t        bus_op,
    output cpu_pkg::addr_sel_t      addr_sel,
    output cpu_pkg::wb_sel_t        wb_sel,
    output logic                    reg_we,
    output logic                    pc_we,
    output logic                    instr_we
);

    typedef enum logic [4:0] {
        S_RESET, S_FETCH, S_FETCH_WAIT, S_DECODE,
        S_OP, S_OP_IMM, S_LUI, S_AUIPC, S_WB_ALU,
        S_LOAD_ADDR, S_LOAD, S_LOAD_WAIT,
        S_STORE_ADDR, S_STORE, S_STORE_WAIT,
        S_JUMP, S_LINK, S_BRANCH, S_BRANCH_TEST,
        S_PC_IMM, S_PC_NEXT, S_PC_UPDATE
    } state_t;

    state_t state, next;
    logic alt_op, alt_imm, taken, load_ok, store_ok;
    cpu_pkg::bus_op_t load_op, store_op;

    // alt only means sub for add, and sra for shifts
    assign alt_op  = alt && (funct3 == 3'b000 || funct3 == 3'b101);
    assign alt_imm = alt && (funct3 == 3'b101);

    assign load_ok  = funct3 == cpu_pkg::F3_BYTE || funct3 == cpu_pkg::F3_WORD
                      || funct3 == cpu_pkg::F3_BYTE_U;
    assign store_ok = funct3 == cpu_pkg::F3_BYTE || funct3 == cpu_pkg::F3_WORD;
    assign load_op  = (funct3 == cpu_pkg::F3_BYTE)   ? cpu_pkg::BUS_READ_B :
                      (funct3 == cpu_pkg::F3_BYTE_U) ? cpu_pkg::BUS_READ_BU :
                      cpu_pkg::BUS_READ_W;
    assign store_op = (funct3 == cpu_pkg::F3_BYTE) ? cpu_pkg::BUS_WRITE_B :
                      cpu_pkg::BUS_WRITE_W;

    always_comb begin
        case (funct3)
            cpu_pkg::F3_BEQ:  taken = eq;
            cpu_pkg::F3_BNE:  taken = !eq;
            cpu_pkg::F3_BLT:  taken = lt;
            cpu_pkg::F3_BGE:  taken = !lt;
            cpu_pkg::F3_BLTU: taken = ltu;
            cpu_pkg::F3_BGEU: taken = !ltu;
            default:          taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next     = state;
        alu_en   = 1'b0;
        alu_op   = cpu_pkg::ALU_ADD;
        s1_sel   = cpu_pkg::S1_REG1;
        s2_sel   = cpu_pkg::S2_REG2;
        bus_en   = 1'b0;
        bus_op   = cpu_pkg::BUS_READ_W;
        addr_sel = cpu_pkg::ADDR_PC;
        wb_sel   = cpu_pkg::WB_ALU;
        reg_we   = 1'b0;
        pc_we    = 1'b0;
        instr_we = 1'b0;
        case (state)
            S_RESET: next = S_FETCH;
            S_FETCH: begin
                bus_en = 1'b1;
                next   = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                if (!busy) begin
                    instr_we = 1'b1;
                    next     = S_DECODE;
                end
            end
            S_DECODE: begin
                case (opcode)
                    cpu_pkg::OPC_OP:       next = S_OP;
                    cpu_pkg::OPC_OP_IMM:   next = S_OP_IMM;
                    cpu_pkg::OPC_LUI:      next = S_LUI;
                    cpu_pkg::OPC_AUIPC:    next = S_AUIPC;
                    cpu_pkg::OPC_LOAD:     next = load_ok ? S_LOAD_ADDR : S_PC_NEXT;
                    cpu_pkg::OPC_STORE:    next = store_ok ? S_STORE_ADDR : S_PC_NEXT;
                    cpu_pkg::OPC_JAL,
                    cpu_pkg::OPC_JALR:     next = S_JUMP;
                    cpu_pkg::OPC_BRANCH:   next = S_BRANCH;
                    cpu_pkg::OPC_MISC_MEM: next = S_PC_NEXT;  // fence
                    default:               next = S_PC_NEXT;
                endcase
            end
            S_OP: begin
                alu_en = 1'b1;
                alu_op = cpu_pkg::alu_op_t'({alt_op, funct3});
                next   = S_WB_ALU;
            end
            S_OP_IMM: begin
                alu_en = 1'b1;
                alu_op = cpu_pkg::alu_op_t'({alt_imm, funct3});
                s2_sel = cpu_pkg::S2_IMM;
                next   = S_WB_ALU;
            end
            S_LUI: begin
                reg_we = 1'b1;
                wb_sel = cpu_pkg::WB_IMM;
                next   = S_PC_NEXT;
            end
            S_AUIPC: begin
                alu_en = 1'b1;
                s1_sel = cpu_pkg::S1_PC;
                s2_sel = cpu_pkg::S2_IMM;
                next   = S_WB_ALU;
            end
            S_WB_ALU: begin
                reg_we = 1'b1;
                next   = S_PC_NEXT;
            end
            S_LOAD_ADDR, S_STORE_ADDR: begin
                alu_en = 1'b1;
                s2_sel = cpu_pkg::S2_IMM;
                next   = (state == S_LOAD_ADDR) ? S_LOAD : S_STORE;
            end
            S_LOAD: begin
                bus_en   = 1'b1;
                bus_op   = load_op;
                addr_sel = cpu_pkg::ADDR_ALU;
                next     = S_LOAD_WAIT;
            end
            S_LOAD_WAIT: begin
                if (!busy) begin
                    reg_we = 1'b1;
                    wb_sel = cpu_pkg::WB_BUS;
                    next   = S_PC_NEXT;
                end
            end
            S_STORE: begin
                bus_en   = 1'b1;
                bus_op   = store_op;
                addr_sel = cpu_pkg::ADDR_ALU;
                next     = S_STORE_WAIT;
            end
            S_STORE_WAIT: begin
                if (!busy) begin
                    next = S_PC_NEXT;
                end
            end
            S_JUMP: begin  // link value pc + 4
                alu_en = 1'b1;
                s1_sel = cpu_pkg::S1_PC;
                s2_sel = cpu_pkg::S2_INSTLEN;
                next   = S_LINK;
            end
            S_LINK: begin
                // target uses rs1 before the link write lands
                reg_we = 1'b1;
                alu_en = 1'b1;
                s1_sel = (opcode == cpu_pkg::OPC_JAL) ? cpu_pkg::S1_PC : cpu_pkg::S1_REG1;
                s2_sel = cpu_pkg::S2_IMM;
                next   = S_PC_UPDATE;
            end
            S_BRANCH: begin
                alu_en = 1'b1;  // flags only
                next   = S_BRANCH_TEST;
            end
            S_BRANCH_TEST: next = taken ? S_PC_IMM : S_PC_NEXT;
            S_PC_IMM: begin
                alu_en = 1'b1;
                s1_sel = cpu_pkg::S1_PC;
                s2_sel = cpu_pkg::S2_IMM;
                next   = S_PC_UPDATE;
            end
            S_PC_NEXT: begin
                alu_en = 1'b1;
                s1_sel = cpu_pkg::S1_PC;
                s2_sel = cpu_pkg::S2_INSTLEN;
                next   = S_PC_UPDATE;
            end
            S_PC_UPDATE: begin
                pc_we = 1'b1;
                next  = S_FETCH;
            end
            default: next = S_RESET;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/bus_wb8.sv
`default_nettype none

module bus_wb8 (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   en,
    input  wire cpu_pkg::bus_op_t op,
    input  wire cpu_pkg::word_t   addr,
    input  wire cpu_pkg::word_t   data,
    input  wire                   ack,
    input  wire [7:0]             rdata,
    output logic                  busy,
    output cpu_pkg::word_t        result,
    output cpu_pkg::word_t        adr,
    output logic [7:0]            wdata,
    output logic                  cyc,
    output logic                  stb,
    output logic                  we
);

    cpu_pkg::bus_op_t op_q;
    logic [1:0] remaining;     // bytes still to go after this one
    cpu_pkg::word_t shift;     // store data, next byte in [7:0]
    cpu_pkg::word_t assembly;  // read bytes shift in from the top
    logic is_word, is_write;

    assign is_word  = (op == cpu_pkg::BUS_READ_W) || (op == cpu_pkg::BUS_WRITE_W);
    assign is_write = (op == cpu_pkg::BUS_WRITE_W) || (op == cpu_pkg::BUS_WRITE_B);
    assign stb      = cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            cyc       <= 1'b0;
            we        <= 1'b0;
            remaining <= 2'd0;
        end else if (en) begin
            busy      <= 1'b1;
            cyc       <= 1'b1;
            we        <= is_write;
            remaining <= is_word ? 2'd3 : 2'd0;
        end else if (cyc) begin
            if (ack) begin
                cyc  <= 1'b0;
                busy <= (remaining != 2'd0);
            end
        end else if (busy) begin
            cyc       <= 1'b1;  // next byte after one idle cycle
            remaining <= remaining - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op_q  <= op;
            adr   <= addr;
            shift <= data;
            wdata <= data[7:0];
        end else if (cyc && ack) begin
            assembly <= {rdata, assembly[31:8]};
            shift    <= shift >> 8;
        end else if (!cyc && busy) begin
            adr   <= adr + 32'd1;
            wdata <= shift[7:0];
        end
    end

    // a single byte ends up in the top lane
    always_comb begin
        case (op_q)
            cpu_pkg::BUS_READ_B:  result = {{24{assembly[31]}}, assembly[31:24]};
            cpu_pkg::BUS_READ_BU: result = {24'b0, assembly[31:24]};
            default:              result = assembly;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   en,
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::word_t   s1,
    input  wire cpu_pkg::word_t   s2,
    output cpu_pkg::word_t        result,
    output logic                  lt,
    output logic                  ltu,
    output logic                  eq
);

    cpu_pkg::word_t value;
    logic signed_lt, unsigned_lt;
    logic [4:0] shamt;

    assign signed_lt   = $signed(s1) < $signed(s2);
    assign unsigned_lt = s1 < s2;
    assign shamt       = s2[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  value = s1 + s2;
            cpu_pkg::ALU_SUB:  value = s1 - s2;
            cpu_pkg::ALU_SLL:  value = s1 << shamt;
            cpu_pkg::ALU_SLT:  value = {31'b0, signed_lt};
            cpu_pkg::ALU_SLTU: value = {31'b0, unsigned_lt};
            cpu_pkg::ALU_XOR:  value = s1 ^ s2;
            cpu_pkg::ALU_SRL:  value = s1 >> shamt;
            cpu_pkg::ALU_SRA:  value = $unsigned($signed(s1) >>> shamt);
            cpu_pkg::ALU_OR:   value = s1 | s2;
            cpu_pkg::ALU_AND:  value = s1 & s2;
            default:           value = s1 + s2;
        endcase
    end

    // result and flags hold until the next en
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            lt     <= 1'b0;
            ltu    <= 1'b0;
            eq     <= 1'b0;
        end else if (en) begin
            result <= value;
            lt     <= signed_lt;
            ltu    <= unsigned_lt;
            eq     <= (s1 == s2);
        end
    end

endmodule

`default_nettype wire

//--- logic/registers.sv
`default_nettype none

module registers (
    input  wire                     clk,
    input  wire cpu_pkg::reg_addr_t rs1,
    input  wire cpu_pkg::reg_addr_t rs2,
    input  wire cpu_pkg::reg_addr_t rd,
    input  wire                     we,
    input  wire cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t          val1,
    output cpu_pkg::word_t          val2
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign val1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign val2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/decoder.sv
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::opcode_t    opcode,
    output cpu_pkg::reg_addr_t  rs1,
    output cpu_pkg::reg_addr_t  rs2,
    output cpu_pkg::reg_addr_t  rd,
    output logic [2:0]          funct3,
    output logic                alt,
    output cpu_pkg::word_t      imm
);

    assign opcode = cpu_pkg::opcode_t'(instr[6:2]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign alt    = instr[30];   // sub / sra

    always_comb begin
        case (opcode)
            cpu_pkg::OPC_STORE: begin
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            end
            cpu_pkg::OPC_BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::OPC_LUI,
            cpu_pkg::OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            cpu_pkg::OPC_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                // I format: op-imm, load, jalr
                imm = {{21{instr[31]}}, instr[30:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011
    } opcode_t;

    // low three bits follow funct3, bit 3 selects sub and sra
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        BUS_READ_W,
        BUS_READ_B,
        BUS_READ_BU,
        BUS_WRITE_W,
        BUS_WRITE_B
    } bus_op_t;

    typedef enum logic {
        S1_REG1,
        S1_PC
    } s1_sel_t;

    typedef enum logic [1:0] {
        S2_REG2,
        S2_IMM,
        S2_INSTLEN
    } s2_sel_t;

    typedef enum logic {
        ADDR_ALU,
        ADDR_PC
    } addr_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_BUS,
        WB_IMM
    } wb_sel_t;

    localparam word_t instr_len = 32'd4;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load / store widths
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;

endpackage

`default_nettype wire
